/* hdl/accumulateStage.sv */
/*
 * Final stage. Shifts and adds the sixteen sub-products into the
 * 64-bit product, updates the accumulator for opMult and opMadd, and
 * holds each result in an output register until outReady.
 */

`timescale 1ns/1ps

module accumulateStage (
    input  logic             Clock,
    input  logic             nReset,
    partialIf.sink           in,
    output logic             outValid,
    input  logic             outReady,
    output arithPkg::resultT outResult
);

    arithPkg::resultT product;
    arithPkg::resultT accumulator;
    arithPkg::resultT nextAccumulator;
    arithPkg::resultT nextResult;
    logic             take;

    // ----------------------------------------
    // Shift and add

    // Each sub-product sits at eight times the sum of its byte positions
    always_comb begin
        product = '0;
        for (int i = 0; i < arithPkg::bytesPerOperand; i++) begin
            for (int j = 0; j < arithPkg::bytesPerOperand; j++) begin
                product = product +
                    (arithPkg::resultT'(in.subProducts[i*arithPkg::bytesPerOperand + j])
                        << (arithPkg::byteWidth * (i + j)));
            end
        end
    end

    // ----------------------------------------
    // Accumulator and result select

    always_comb begin
        nextAccumulator = accumulator;
        nextResult      = arithPkg::resultT'(in.count);
        case (in.op)
            opPkg::opMult: begin
                nextAccumulator = product;
                nextResult      = product;
            end
            opPkg::opMadd: begin
                nextAccumulator = accumulator + product;
                nextResult      = accumulator + product;
            end
            // Counts leave the accumulator alone
            default: begin
                nextAccumulator = accumulator;
            end
        endcase
    end

    // Take a record when the output slot is empty or draining
    assign in.ready = !outValid || outReady;
    assign take     = in.valid && in.ready;

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            accumulator <= '0;
            outValid    <= 1'b0;
        end else if (take) begin
            accumulator <= nextAccumulator;
            outValid    <= 1'b1;
        end else if (outReady) begin
            outValid    <= 1'b0;
        end
    end

    // ----------------------------------------
    // Output register

    always_ff @(posedge Clock) begin
        if (take) begin
            outResult <= nextResult;
        end
    end

endmodule

/* hdl/arithPkg.sv */
/*
 * Widths and vector types of the multiply-accumulate datapath.
 * Operands are split into bytes, and each byte pair gives one
 * sub-product. Refer to these by scoped name.
 */

package arithPkg;

    // ----------------------------------------
    // Widths
    localparam int operandWidth    = 32;
    localparam int byteWidth       = 8;
    localparam int bytesPerOperand = operandWidth / byteWidth;
    localparam int subProductCount = bytesPerOperand * bytesPerOperand;
    localparam int countWidth      = 6;

    // ----------------------------------------
    // Vector types
    typedef logic [operandWidth-1:0]   operandT;
    typedef logic [2*byteWidth-1:0]    subProductT;

    // Index is aByte * bytesPerOperand + bByte
    typedef subProductT                subProductsT [subProductCount];

    // Holds 0 to 32
    typedef logic [countWidth-1:0]     countT;
    typedef logic [2*operandWidth-1:0] resultT;

endpackage

/* hdl/mulAccUnit.sv */
/*
 * Pipelined unsigned multiply-accumulate unit with leading zero and
 * leading one counts. Operands enter and results leave through
 * valid/ready handshakes, and results come out in input order.
 */

`timescale 1ns/1ps

module mulAccUnit (
    input  logic              Clock,
    input  logic              nReset,
    input  logic              inValid,
    output logic              inReady,
    input  opPkg::macOpT      inOp,
    input  arithPkg::operandT inA,
    input  arithPkg::operandT inB,
    output logic              outValid,
    input  logic              outReady,
    output arithPkg::resultT  outResult
);

    // ----------------------------------------
    // Stage links

    partialIf prodToBuf ();
    partialIf bufToCons ();

    // ----------------------------------------
    // Sub-product stage

    partialProducts producer0 (
        .Clock   (Clock    ),
        .nReset  (nReset   ),
        .inValid (inValid  ),
        .inReady (inReady  ),
        .inOp    (inOp     ),
        .inA     (inA      ),
        .inB     (inB      ),
        .out     (prodToBuf)
    );

    // ----------------------------------------
    // Record FIFO

    partialBuffer buffer0 (
        .Clock  (Clock    ),
        .nReset (nReset   ),
        .in     (prodToBuf),
        .out    (bufToCons)
    );

    // ----------------------------------------
    // Sum and accumulate

    accumulateStage consumer0 (
        .Clock     (Clock    ),
        .nReset    (nReset   ),
        .in        (bufToCons),
        .outValid  (outValid ),
        .outReady  (outReady ),
        .outResult (outResult)
    );

endmodule

/* hdl/opPkg.sv */
/*
 * Operation codes of the multiply-accumulate unit and the depth
 * of the sub-product FIFO between producer and consumer.
 */

package opPkg;

    // ----------------------------------------
    // Operations
    typedef enum logic [1:0] {
        opMult,
        opMadd,
        opClz,
        opClo
    } macOpT;

    // ----------------------------------------
    // FIFO sizing

    // Depth must stay a power of two so the pointers wrap
    localparam int bufferDepth      = 4;
    localparam int bufferIndexWidth = 2;

endpackage

/* hdl/partialBuffer.sv */
/*
 * FIFO of sub-product records between producer and consumer.
 * Keeps records in order and absorbs consumer stalls. Ready on the
 * input side falls only when every entry is full.
 */

`timescale 1ns/1ps

module partialBuffer (
    input  logic     Clock,
    input  logic     nReset,
    partialIf.sink   in,
    partialIf.source out
);

    localparam logic [opPkg::bufferIndexWidth:0] fullCount =
        (opPkg::bufferIndexWidth + 1)'(opPkg::bufferDepth);

    opPkg::macOpT          opMem      [opPkg::bufferDepth];
    arithPkg::subProductsT productMem [opPkg::bufferDepth];
    arithPkg::countT       countMem   [opPkg::bufferDepth];

    logic [opPkg::bufferIndexWidth-1:0] writePtr;
    logic [opPkg::bufferIndexWidth-1:0] readPtr;
    logic [opPkg::bufferIndexWidth:0]   occupancy;
    logic                               push;
    logic                               pop;

    assign in.ready  = (occupancy != fullCount);
    assign out.valid = (occupancy != '0);

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    // ----------------------------------------
    // Storage

    always_ff @(posedge Clock) begin
        if (push) begin
            opMem[writePtr]      <= in.op;
            productMem[writePtr] <= in.subProducts;
            countMem[writePtr]   <= in.count;
        end
    end

    assign out.op          = opMem[readPtr];
    assign out.subProducts = productMem[readPtr];
    assign out.count       = countMem[readPtr];

    // ----------------------------------------
    // Pointers and occupancy

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            writePtr  <= '0;
            readPtr   <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                writePtr <= writePtr + 1'b1;
            end
            if (pop) begin
                readPtr <= readPtr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

/* hdl/partialIf.sv */
/*
 * One sub-product record with a valid/ready handshake.
 * The source side drives the record and valid, the sink side
 * drives ready. A transfer happens on a Clock edge with both high.
 */

`timescale 1ns/1ps

interface partialIf;

    logic                  valid;
    logic                  ready;
    opPkg::macOpT          op;
    arithPkg::subProductsT subProducts;
    arithPkg::countT       count;

    modport source (
        output valid,
        output op,
        output subProducts,
        output count,
        input  ready
    );

    modport sink (
        input  valid,
        input  op,
        input  subProducts,
        input  count,
        output ready
    );

endinterface

/* hdl/partialProducts.sv */
/*
 * First pipeline stage. Takes operands with a valid/ready handshake,
 * forms the sixteen byte-by-byte products and the leading zero or one
 * count of A, and registers them as one record for the FIFO.
 */

`timescale 1ns/1ps

module partialProducts (
    input  logic              Clock,
    input  logic              nReset,
    input  logic              inValid,
    output logic              inReady,
    input  opPkg::macOpT      inOp,
    input  arithPkg::operandT inA,
    input  arithPkg::operandT inB,
    partialIf.source          out
);

    arithPkg::subProductsT subProducts;
    arithPkg::operandT     countSource;
    arithPkg::countT       leadingCount;
    logic                  accept;

    // Counts zeros from the top bit down to the first one
    function automatic arithPkg::countT leadingZeros(arithPkg::operandT value);
        arithPkg::countT count;
        logic            found;
        count = '0;
        found = 1'b0;
        for (int i = arithPkg::operandWidth - 1; i >= 0; i--) begin
            if (value[i]) begin
                found = 1'b1;
            end else if (!found) begin
                count = count + 1'b1;
            end
        end
        return count;
    endfunction

    // ----------------------------------------
    // Sub-products

    always_comb begin
        for (int i = 0; i < arithPkg::bytesPerOperand; i++) begin
            for (int j = 0; j < arithPkg::bytesPerOperand; j++) begin
                subProducts[i*arithPkg::bytesPerOperand + j] =
                    inA[i*arithPkg::byteWidth +: arithPkg::byteWidth] *
                    inB[j*arithPkg::byteWidth +: arithPkg::byteWidth];
            end
        end
    end

    // ----------------------------------------
    // Leading count

    // Leading ones of A are the leading zeros of its inverse
    assign countSource  = (inOp == opPkg::opClo) ? ~inA : inA;
    assign leadingCount = leadingZeros(countSource);

    // ----------------------------------------
    // Pipeline register

    // Free when empty or when the held record leaves this cycle
    assign inReady = !out.valid || out.ready;
    assign accept  = inValid && inReady;

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            out.valid <= 1'b0;
        end else if (accept) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge Clock) begin
        if (accept) begin
            out.op          <= inOp;
            out.subProducts <= subProducts;
            out.count       <= leadingCount;
        end
    end

endmodule

/* list.f */
hdl/arithPkg.sv
hdl/opPkg.sv
hdl/partialIf.sv
hdl/partialProducts.sv
hdl/partialBuffer.sv
hdl/accumulateStage.sv
hdl/mulAccUnit.sv
tb/mulAccUnit_asserts.sv
tb/mulAccTb.sv

/* tb/mulAccTb.sv */
/*
 * Testbench for the multiply-accumulate unit. Drives random operations
 * from an LFSR, keeps its own accumulator as a model and checks every
 * result in order. Run with the file list; prints a line per test.
 */

`timescale 1ns/1ps

module mulAccTb;

    localparam int modeReset  = 0;
    localparam int modeMult   = 1;
    localparam int modeChain  = 2;
    localparam int modeCount  = 3;
    localparam int modeBusy   = 4;
    localparam int totalItems = 1 + 200 + 150 + 120 + 200;
    localparam int cycleLimit = 40 * totalItems;

    logic              Clock;
    logic              nReset;
    logic              inValid;
    logic              inReady;
    opPkg::macOpT      inOp;
    arithPkg::operandT inA;
    arithPkg::operandT inB;
    logic              outValid;
    logic              outReady;
    arithPkg::resultT  outResult;

    logic [31:0]      lfsrState = 32'hea96_2574;
    arithPkg::resultT modelAcc;
    arithPkg::resultT expectQ [$];
    int               cycles;
    int               testErrors;
    int               testsPassed;
    int               testsFailed;

    mulAccUnit dut0 (
        .Clock     (Clock    ),
        .nReset    (nReset   ),
        .inValid   (inValid  ),
        .inReady   (inReady  ),
        .inOp      (inOp     ),
        .inA       (inA      ),
        .inB       (inB      ),
        .outValid  (outValid ),
        .outReady  (outReady ),
        .outResult (outResult)
    );

    always #2 Clock = ~Clock;

    always @(posedge Clock) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Random numbers and operand choice

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] randomBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        end
        return value;
    endfunction

    // Edge values mixed in with plain random ones
    function automatic arithPkg::operandT pickOperand();
        case (randomBits(3))
            0:       return '0;
            1:       return '1;
            2:       return 32'h1 << randomBits(5);
            3:       return ~(32'h1 << randomBits(5));
            default: return randomBits(32);
        endcase
    endfunction

    function automatic opPkg::macOpT randomOp();
        case (randomBits(2))
            0:       return opPkg::opMult;
            1:       return opPkg::opMadd;
            2:       return opPkg::opClz;
            default: return opPkg::opClo;
        endcase
    endfunction

    // ----------------------------------------
    // Reference model

    function automatic arithPkg::resultT leadingRun(arithPkg::operandT a, logic digit);
        int n;
        n = 0;
        while (n < 32 && a[31 - n] == digit) begin
            n++;
        end
        return arithPkg::resultT'(n);
    endfunction

    function automatic arithPkg::resultT modelStep(opPkg::macOpT op, arithPkg::operandT a,
                                                   arithPkg::operandT b);
        arithPkg::resultT product;
        product = arithPkg::resultT'(a) * arithPkg::resultT'(b);
        case (op)
            opPkg::opMult: modelAcc = product;
            opPkg::opMadd: modelAcc = modelAcc + product;
            opPkg::opClz:  return leadingRun(a, 1'b0);
            default:       return leadingRun(a, 1'b1);
        endcase
        return modelAcc;
    endfunction

    task automatic makeItem(input int mode);
        case (mode)
            modeReset: inOp = opPkg::opMadd;
            modeMult:  inOp = opPkg::opMult;
            modeChain: inOp = (randomBits(2) == 0) ? opPkg::opMult : opPkg::opMadd;
            default:   inOp = randomOp();
        endcase
        inA     = (mode == modeMult || mode == modeCount) ? pickOperand() : randomBits(32);
        inB     = (mode == modeMult) ? pickOperand() : randomBits(32);
        inValid = 1'b1;
    endtask

    // ----------------------------------------
    // One test: send items, check results in order

    task automatic runTest(input string name, input int items, input int mode);
        int               sent;
        int               received;
        logic             taken;
        arithPkg::resultT expected;
        sent       = 0;
        received   = 0;
        taken      = 1'b0;
        testErrors = 0;
        if (mode == modeReset) begin
            assert (outValid === 1'b0) else begin
                $display("outValid is high right after reset in test %s", name);
                testErrors++;
            end
            assert (inReady === 1'b1) else begin
                $display("inReady is low right after reset in test %s", name);
                testErrors++;
            end
        end
        while (received < items) begin
            @(negedge Clock);
            if (taken || !inValid) begin
                inValid = 1'b0;
                if (sent < items && (mode != modeBusy || randomBits(1))) begin
                    makeItem(mode);
                end
            end
            outReady = (mode == modeBusy) ? randomBits(1) : 1'b1;
            taken    = 1'b0;
            #1;
            if (inValid && inReady) begin
                expectQ.push_back(modelStep(inOp, inA, inB));
                sent++;
                taken = 1'b1;
            end
            if (outValid && outReady) begin
                received++;
                assert (expectQ.size() > 0) else begin
                    $display("result appeared with no input pending in test %s", name);
                    testErrors++;
                end
                if (expectQ.size() > 0) begin
                    expected = expectQ.pop_front();
                    assert (outResult === expected) else begin
                        $display("error %s expected %h actual %h", name, expected, outResult);
                        testErrors++;
                    end
                end
            end
        end
        $display("test %s: %0d items, %0d errors", name, items, testErrors);
        if (testErrors == 0) begin
            testsPassed++;
        end else begin
            testsFailed++;
        end
    endtask

    initial begin
        Clock       = 1'b0;
        nReset      = 1'b0;
        inValid     = 1'b0;
        inOp        = opPkg::opMult;
        inA         = '0;
        inB         = '0;
        outReady    = 1'b1;
        modelAcc    = '0;
        cycles      = 0;
        testsPassed = 0;
        testsFailed = 0;
        repeat (5) @(posedge Clock);
        @(negedge Clock);
        nReset = 1'b1;

        runTest("resetState", 1, modeReset);
        runTest("multiply", 200, modeMult);
        runTest("accumulateChain", 150, modeChain);
        runTest("leadingCounts", 120, modeCount);
        runTest("backPressure", 200, modeBusy);

        $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 testsPassed, testsFailed, dut0.asserts0.failCount);
        if (testsFailed == 0 && dut0.asserts0.failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb/mulAccUnit_asserts.sv */
/*
 * Concurrent checks on the output handshake of the unit.
 * Bound to every mulAccUnit instance at elaboration.
 */

`timescale 1ns/1ps

module mulAccUnit_asserts (
    input logic             Clock,
    input logic             nReset,
    input logic             outValid,
    input logic             outReady,
    input arithPkg::resultT outResult
);

    // Failed assertions so far
    int failCount = 0;

    // Result waits for the consumer
    property validHeld;
        @(posedge Clock) disable iff (!nReset)
            outValid && !outReady |=> outValid;
    endproperty

    property resultStable;
        @(posedge Clock) disable iff (!nReset)
            outValid && !outReady |=> $stable(outResult);
    endproperty

    property quietInReset;
        @(posedge Clock) !nReset |-> !outValid;
    endproperty

    assert property (validHeld) else begin
        $error("outValid fell before outReady");
        failCount++;
    end
    assert property (resultStable) else begin
        $error("outResult changed while stalled");
        failCount++;
    end
    assert property (quietInReset) else begin
        $error("outValid high during reset");
        failCount++;
    end

endmodule

bind mulAccUnit mulAccUnit_asserts asserts0 (
    .Clock     (Clock    ),
    .nReset    (nReset   ),
    .outValid  (outValid ),
    .outReady  (outReady ),
    .outResult (outResult)
);
